/* sources.f */
+incdir+common
common/dcache_pkg.sv
dcache/dcache_ctrl.sv
dcache/dcache_axi_bridge.sv
src/dcache_top.sv
tests/axi_mem_model.sv
tests/tb_dcache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_dcache
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int    N_RANDOM       = 300;
    localparam int    CYCLES_PER_OP  = 50;
    localparam int    TIMEOUT_CYCLES = (N_RANDOM + 100) * CYCLES_PER_OP;  // margin for directed
    localparam addr_t LINE_A         = 32'h0000_0100;                     // index 8, tag 0

    logic   clock = 1'b0;
    logic   reset = 1'b0;
    logic   req_valid = 1'b0;
    logic   req_write = 1'b0;
    addr_t  req_addr = '0;
    word_t  req_wdata = '0;
    strb_t  req_wstrb = '0;
    logic   resp_ready = 1'b0;
    logic   req_ready, resp_valid;
    word_t  resp_rdata;

    logic   aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    logic   ar_valid, ar_ready, r_valid, r_ready, r_last;
    addr_t  aw_addr, ar_addr;
    word_t  w_data, r_data;
    strb_t  w_strb;
    logic [31:0] ar_count, aw_count;

    word_t       ref_mem [1024];    // flat memory as the cpu should see it
    word_t       exp_q [$];
    logic [31:0] stim_lfsr = 32'h186d;
    logic [31:0] ready_lfsr = 32'h186d;
    logic        hold_ready = 1'b0;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    dcache_top UUT (
        .clock(clock), .reset(reset),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_wdata_i(req_wdata), .req_wstrb_i(req_wstrb),
        .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_rdata_o(resp_rdata),
        .axi_aw_valid_o(aw_valid), .axi_aw_ready_i(aw_ready), .axi_aw_addr_o(aw_addr),
        .axi_w_valid_o(w_valid), .axi_w_ready_i(w_ready), .axi_w_data_o(w_data),
        .axi_w_strb_o(w_strb), .axi_w_last_o(w_last),
        .axi_b_valid_i(b_valid), .axi_b_ready_o(b_ready),
        .axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready), .axi_ar_addr_o(ar_addr),
        .axi_r_valid_i(r_valid), .axi_r_ready_o(r_ready), .axi_r_data_i(r_data),
        .axi_r_last_i(r_last)
    );

    axi_mem_model u_mem (
        .clock(clock), .reset(reset),
        .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
        .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data),
        .w_strb_i(w_strb), .w_last_i(w_last),
        .b_valid_o(b_valid), .b_ready_i(b_ready),
        .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
        .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_last_o(r_last),
        .ar_count_o(ar_count), .aw_count_o(aw_count)
    );

    initial begin
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // n fresh bits from the stimulus generator
    function automatic logic [31:0] random_bits(input int n);
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return stim_lfsr & ((n >= 32) ? 32'hffff_ffff : ((32'h1 << n) - 32'h1));
    endfunction

    function automatic word_t fill_pattern(input addr_t a);
        return {a ^ 32'h5a5a_c3c3, (a * 32'h9e37_79b9) ^ 32'h0f0f_1234};
    endfunction

    // expected response word, stores update the flat memory
    function automatic word_t reference_access(input logic wr, input addr_t a,
                                               input word_t wdata, input strb_t wstrb);
        word_t w;
        w = ref_mem[a[12:3]];
        if (wr) begin
            for (int b = 0; b < 8; b++) begin
                if (wstrb[b]) begin
                    w[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            ref_mem[a[12:3]] = w;
        end
        return w;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic send_request(input logic wr, input addr_t a, input word_t wdata,
                                input strb_t wstrb);
        @(posedge clock);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= a;
        req_wdata <= wdata;
        req_wstrb <= wstrb;
        do begin
            @(posedge clock);
        end while (!req_ready);
        req_valid <= 1'b0;
        exp_q.push_back(reference_access(wr, a, wdata, wstrb));
    endtask

    task automatic wait_response();
        do begin
            @(posedge clock);
        end while (!(resp_valid && resp_ready));
        @(negedge clock);   // compare process is done with this edge
    endtask

    task automatic access(input logic wr, input addr_t a, input word_t wdata, input strb_t wstrb);
        send_request(wr, a, wdata, wstrb);
        wait_response();
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %0d errors", name, error_count - errs_before);
    endtask

    always @(posedge clock) begin
        ready_lfsr = lfsr_step(lfsr_step(ready_lfsr));
        resp_ready <= hold_ready ? 1'b0 : (ready_lfsr[1:0] != 2'b00);
    end

    // every accepted response against the oldest expected word
    always @(posedge clock) begin
        if (reset && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("response arrived with no request pending");
            end else begin
                check_value("resp_rdata_o", resp_rdata, exp_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int          errs;
        logic [31:0] ar_base, aw_base, r;
        logic        wr;
        addr_t       a;
        word_t       d, held;

        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_pattern(addr_t'(i * 8));
        end
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);

        errs = error_count;
        check_value("req_ready_o", 64'(req_ready), 64'd1);
        check_value("resp_valid_o", 64'(resp_valid), 64'd0);
        check_value("axi_ar_valid_o", 64'(ar_valid), 64'd0);
        check_value("axi_aw_valid_o", 64'(aw_valid), 64'd0);
        check_value("axi_w_valid_o", 64'(w_valid), 64'd0);
        check_value("axi_b_ready_o", 64'(b_ready), 64'd0);
        check_value("axi_r_ready_o", 64'(r_ready), 64'd0);
        report_test("reset_state", errs);

        errs = error_count;
        ar_base = ar_count;
        access(1'b0, LINE_A, '0, '0);
        check_value("ar_count", 64'(ar_count - ar_base), 64'd1);
        report_test("cold_read_miss", errs);

        errs = error_count;
        ar_base = ar_count;
        access(1'b0, LINE_A + 32'd8, '0, '0);
        check_value("ar_count", 64'(ar_count - ar_base), 64'd0);
        report_test("read_hit", errs);

        errs = error_count;
        access(1'b1, LINE_A + 32'd16, 64'h1122_3344_5566_7788, 8'b0101_1010);
        access(1'b0, LINE_A + 32'd16, '0, '0);
        report_test("store_merge", errs);

        // same index, other tag, victim line is dirty
        errs = error_count;
        aw_base = aw_count;
        access(1'b0, LINE_A ^ 32'h0000_0200, '0, '0);
        check_value("aw_count", 64'(aw_count - aw_base), 64'd1);
        access(1'b0, LINE_A + 32'd16, '0, '0);
        check_value("aw_count", 64'(aw_count - aw_base), 64'd1);
        report_test("dirty_eviction", errs);

        errs = error_count;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = random_bits(1);
            wr = r[0];
            r = random_bits(8);
            a = {21'd0, r[7:0], 3'd0};  // 64 lines of 4 words
            d[63:32] = random_bits(32);
            d[31:0] = random_bits(32);
            r = random_bits(8);
            access(wr, a, d, r[7:0]);
        end
        report_test("random_traffic", errs);

        errs = error_count;
        @(negedge clock);
        hold_ready = 1'b1;
        send_request(1'b0, 32'h0000_0408, '0, '0);
        do begin
            @(posedge clock);
        end while (!resp_valid);
        held = resp_rdata;
        repeat (6) begin
            @(posedge clock);
            check_value("resp_valid_o", 64'(resp_valid), 64'd1);
            check_value("resp_rdata_o", resp_rdata, held);
            check_value("req_ready_o", 64'(req_ready), 64'd0);
        end
        @(negedge clock);
        hold_ready = 1'b0;
        wait_response();
        report_test("response_backpressure", errs);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tests/axi_mem_model.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module axi_mem_model
    import dcache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        aw_valid_i,
    output logic        aw_ready_o,
    input  addr_t       aw_addr_i,
    input  logic        w_valid_i,
    output logic        w_ready_o,
    input  word_t       w_data_i,
    input  strb_t       w_strb_i,
    input  logic        w_last_i,
    output logic        b_valid_o,
    input  logic        b_ready_i,
    input  logic        ar_valid_i,
    output logic        ar_ready_o,
    input  addr_t       ar_addr_i,
    output logic        r_valid_o,
    input  logic        r_ready_i,
    output word_t       r_data_o,
    output logic        r_last_o,
    output logic [31:0] ar_count_o,
    output logic [31:0] aw_count_o
);

    localparam int MEM_WORDS = 1024;    // 8 KB, addresses alias above that

    word_t          mem [MEM_WORDS];
    logic [31:0]    lfsr_q;             // stall bits, 8 new ones per cycle
    logic           wr_active_q, b_valid_q, rd_active_q, r_valid_q;
    addr_t          wr_addr_q, rd_addr_q;
    beat_t          wr_beat_q, rd_beat_q;

    function automatic logic [31:0] lfsr_advance(input logic [31:0] s, input int n);
        logic [31:0] v;
        v = s;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return {a ^ 32'h5a5a_c3c3, (a * 32'h9e37_79b9) ^ 32'h0f0f_1234};
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= fill_word(addr_t'(i * 8));
        end
    end

    // each ready is up about three cycles in four
    assign ar_ready_o = !rd_active_q && (lfsr_q[1:0] != 2'b00);
    assign aw_ready_o = !wr_active_q && !b_valid_q && (lfsr_q[3:2] != 2'b00);
    assign w_ready_o  = wr_active_q && (lfsr_q[5:4] != 2'b00);
    assign b_valid_o  = b_valid_q;
    assign r_valid_o  = r_valid_q;
    assign r_data_o   = mem[{rd_addr_q[12:5], rd_beat_q}];
    assign r_last_o   = r_valid_q && (rd_beat_q == beat_t'(`DC_BEATS - 1));

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            lfsr_q      <= 32'h186d;
            wr_active_q <= 1'b0;
            b_valid_q   <= 1'b0;
            rd_active_q <= 1'b0;
            r_valid_q   <= 1'b0;
            wr_beat_q   <= '0;
            rd_beat_q   <= '0;
            ar_count_o  <= '0;
            aw_count_o  <= '0;
        end else begin
            lfsr_q <= lfsr_advance(lfsr_q, 8);
            if (aw_valid_i && aw_ready_o) begin
                wr_active_q <= 1'b1;
                wr_addr_q   <= aw_addr_i;
                wr_beat_q   <= '0;
                aw_count_o  <= aw_count_o + 32'd1;
            end
            if (w_valid_i && w_ready_o) begin
                wr_beat_q <= wr_beat_q + 1'b1;
                if (w_last_i) begin
                    wr_active_q <= 1'b0;
                    b_valid_q   <= 1'b1;
                end
            end
            if (b_valid_q && b_ready_i) begin
                b_valid_q <= 1'b0;
            end
            if (ar_valid_i && ar_ready_o) begin
                rd_active_q <= 1'b1;
                rd_addr_q   <= ar_addr_i;
                rd_beat_q   <= '0;
                ar_count_o  <= ar_count_o + 32'd1;
            end
            if (r_valid_q && r_ready_i) begin
                r_valid_q <= 1'b0;              // bubble after every beat
                if (rd_beat_q == beat_t'(`DC_BEATS - 1)) begin
                    rd_active_q <= 1'b0;
                end else begin
                    rd_beat_q <= rd_beat_q + 1'b1;
                end
            end else if (rd_active_q && !r_valid_q && (lfsr_q[7:6] != 2'b00)) begin
                r_valid_q <= 1'b1;
            end
        end
    end

    // byte write of the current W beat
    always @(posedge clock) begin
        if (reset && w_valid_i && w_ready_o) begin
            for (int b = 0; b < 8; b++) begin
                if (w_strb_i[b]) begin
                    mem[{wr_addr_q[12:5], wr_beat_q}][b*8 +: 8] <= w_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic    clock,
    input  logic    reset,

    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  logic    req_write_i,
    input  addr_t   req_addr_i,
    input  word_t   req_wdata_i,
    input  strb_t   req_wstrb_i,
    output logic    resp_valid_o,
    input  logic    resp_ready_i,
    output word_t   resp_rdata_o,

    output logic    axi_aw_valid_o,
    input  logic    axi_aw_ready_i,
    output addr_t   axi_aw_addr_o,
    output logic    axi_w_valid_o,
    input  logic    axi_w_ready_i,
    output word_t   axi_w_data_o,
    output strb_t   axi_w_strb_o,
    output logic    axi_w_last_o,
    input  logic    axi_b_valid_i,
    output logic    axi_b_ready_o,
    output logic    axi_ar_valid_o,
    input  logic    axi_ar_ready_i,
    output addr_t   axi_ar_addr_o,
    input  logic    axi_r_valid_i,
    output logic    axi_r_ready_o,
    input  word_t   axi_r_data_i,
    input  logic    axi_r_last_i
);

    // controller <-> bridge
    logic   rd_req_valid, rd_req_ready;
    addr_t  rd_addr;
    logic   rd_beat_valid, rd_beat_last;
    word_t  rd_beat_data;
    logic   wr_req_valid, wr_req_ready, wr_done;
    addr_t  wr_addr;
    line_t  wr_line;

    dcache_ctrl u_ctrl (
        .clock           (clock),
        .reset           (reset),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_wstrb_i     (req_wstrb_i),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_rdata_o    (resp_rdata_o),
        .rd_req_valid_o  (rd_req_valid),
        .rd_req_ready_i  (rd_req_ready),
        .rd_addr_o       (rd_addr),
        .rd_beat_valid_i (rd_beat_valid),
        .rd_beat_data_i  (rd_beat_data),
        .rd_beat_last_i  (rd_beat_last),
        .wr_req_valid_o  (wr_req_valid),
        .wr_req_ready_i  (wr_req_ready),
        .wr_addr_o       (wr_addr),
        .wr_line_o       (wr_line),
        .wr_done_i       (wr_done)
    );

    dcache_axi_bridge u_bridge (
        .clock           (clock),
        .reset           (reset),
        .rd_req_valid_i  (rd_req_valid),
        .rd_req_ready_o  (rd_req_ready),
        .rd_addr_i       (rd_addr),
        .rd_beat_valid_o (rd_beat_valid),
        .rd_beat_data_o  (rd_beat_data),
        .rd_beat_last_o  (rd_beat_last),
        .wr_req_valid_i  (wr_req_valid),
        .wr_req_ready_o  (wr_req_ready),
        .wr_addr_i       (wr_addr),
        .wr_line_i       (wr_line),
        .wr_done_o       (wr_done),
        .axi_aw_valid_o  (axi_aw_valid_o),
        .axi_aw_ready_i  (axi_aw_ready_i),
        .axi_aw_addr_o   (axi_aw_addr_o),
        .axi_w_valid_o   (axi_w_valid_o),
        .axi_w_ready_i   (axi_w_ready_i),
        .axi_w_data_o    (axi_w_data_o),
        .axi_w_strb_o    (axi_w_strb_o),
        .axi_w_last_o    (axi_w_last_o),
        .axi_b_valid_i   (axi_b_valid_i),
        .axi_b_ready_o   (axi_b_ready_o),
        .axi_ar_valid_o  (axi_ar_valid_o),
        .axi_ar_ready_i  (axi_ar_ready_i),
        .axi_ar_addr_o   (axi_ar_addr_o),
        .axi_r_valid_i   (axi_r_valid_i),
        .axi_r_ready_o   (axi_r_ready_o),
        .axi_r_data_i    (axi_r_data_i),
        .axi_r_last_i    (axi_r_last_i)
    );

endmodule

/* dcache/dcache_axi_bridge.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_axi_bridge
    import dcache_pkg::*;
(
    input  logic    clock,
    input  logic    reset,

    input  logic    rd_req_valid_i,
    output logic    rd_req_ready_o,
    input  addr_t   rd_addr_i,
    output logic    rd_beat_valid_o,
    output word_t   rd_beat_data_o,
    output logic    rd_beat_last_o,

    input  logic    wr_req_valid_i,
    output logic    wr_req_ready_o,
    input  addr_t   wr_addr_i,
    input  line_t   wr_line_i,
    output logic    wr_done_o,

    output logic    axi_aw_valid_o,
    input  logic    axi_aw_ready_i,
    output addr_t   axi_aw_addr_o,
    output logic    axi_w_valid_o,
    input  logic    axi_w_ready_i,
    output word_t   axi_w_data_o,
    output strb_t   axi_w_strb_o,
    output logic    axi_w_last_o,
    input  logic    axi_b_valid_i,
    output logic    axi_b_ready_o,
    output logic    axi_ar_valid_o,
    input  logic    axi_ar_ready_i,
    output addr_t   axi_ar_addr_o,
    input  logic    axi_r_valid_i,
    output logic    axi_r_ready_o,
    input  word_t   axi_r_data_i,
    input  logic    axi_r_last_i
);

    axi_wr_state_t  wr_state_q, wr_state_d;
    addr_t          wr_addr_q;
    line_t          wr_line_q;
    beat_t          wr_cnt_q;       // current W beat
    logic           wr_last;

    axi_rd_state_t  rd_state_q, rd_state_d;
    addr_t          rd_addr_q;

    assign wr_last = (wr_cnt_q == beat_t'(`DC_BEATS - 1));

    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            WR_IDLE: if (wr_req_valid_i) wr_state_d = WR_AW;
            WR_AW:   if (axi_aw_ready_i) wr_state_d = WR_W;
            WR_W:    if (axi_w_ready_i && wr_last) wr_state_d = WR_B;
            WR_B:    if (axi_b_valid_i) wr_state_d = WR_IDLE;
            default: wr_state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= WR_IDLE;
            wr_cnt_q   <= '0;
        end else begin
            wr_state_q <= wr_state_d;
            if (wr_state_q == WR_W && axi_w_ready_i) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;   // wraps to 0 after the last beat
            end
        end
    end

    // line captured when the request is taken
    always_ff @(posedge clock) begin
        if (wr_state_q == WR_IDLE && wr_req_valid_i) begin
            wr_addr_q <= wr_addr_i;
            wr_line_q <= wr_line_i;
        end
    end

    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            RD_IDLE: if (rd_req_valid_i) rd_state_d = RD_AR;
            RD_AR:   if (axi_ar_ready_i) rd_state_d = RD_R;
            RD_R:    if (axi_r_valid_i && axi_r_last_i) rd_state_d = RD_IDLE;
            default: rd_state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_state_q <= RD_IDLE;
        end else begin
            rd_state_q <= rd_state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_state_q == RD_IDLE && rd_req_valid_i) begin
            rd_addr_q <= rd_addr_i;
        end
    end

    // write channels
    assign wr_req_ready_o = (wr_state_q == WR_IDLE);
    assign axi_aw_valid_o = (wr_state_q == WR_AW);
    assign axi_aw_addr_o  = wr_addr_q;
    assign axi_w_valid_o  = (wr_state_q == WR_W);
    assign axi_w_data_o   = wr_line_q[wr_cnt_q*`DC_WORD_W +: `DC_WORD_W];
    assign axi_w_strb_o   = '1;                  // whole line always written
    assign axi_w_last_o   = wr_last;             // counter sits at 0 outside WR_W
    assign axi_b_ready_o  = (wr_state_q == WR_B);
    assign wr_done_o      = (wr_state_q == WR_B) && axi_b_valid_i;

    // read channels, beats pass straight through
    assign rd_req_ready_o  = (rd_state_q == RD_IDLE);
    assign axi_ar_valid_o  = (rd_state_q == RD_AR);
    assign axi_ar_addr_o   = rd_addr_q;
    assign axi_r_ready_o   = (rd_state_q == RD_R);
    assign rd_beat_valid_o = axi_r_valid_i && axi_r_ready_o;
    assign rd_beat_data_o  = axi_r_data_i;
    assign rd_beat_last_o  = rd_beat_valid_o && axi_r_last_i;

    aw_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o && $stable(axi_aw_addr_o));

    ar_stable: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o));

    w_last_valid: assert property (@(posedge clock) disable iff (!reset)
        axi_w_last_o |-> axi_w_valid_o);

endmodule

/* dcache/dcache_ctrl.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic    clock,
    input  logic    reset,

    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  logic    req_write_i,
    input  addr_t   req_addr_i,
    input  word_t   req_wdata_i,
    input  strb_t   req_wstrb_i,
    output logic    resp_valid_o,
    input  logic    resp_ready_i,
    output word_t   resp_rdata_o,

    output logic    rd_req_valid_o,
    input  logic    rd_req_ready_i,
    output addr_t   rd_addr_o,
    input  logic    rd_beat_valid_i,
    input  word_t   rd_beat_data_i,
    input  logic    rd_beat_last_i,

    output logic    wr_req_valid_o,
    input  logic    wr_req_ready_i,
    output addr_t   wr_addr_o,
    output line_t   wr_line_o,
    input  logic    wr_done_i
);

    ctrl_state_t    state_q, state_d;

    // direct mapped storage
    line_t                          data_q [1 << `DC_INDEX_W];
    tag_t                           tag_q  [1 << `DC_INDEX_W];
    logic [(1 << `DC_INDEX_W)-1:0]  valid_q;
    logic [(1 << `DC_INDEX_W)-1:0]  dirty_q;

    // pending cpu access
    logic   write_q;
    addr_t  addr_q;
    word_t  wdata_q;
    strb_t  wstrb_q;
    word_t  rdata_q;

    logic   sent_q;     // bridge request already taken in this state
    beat_t  beat_q;     // refill beat position

    index_t idx;
    tag_t   tag;
    beat_t  word_sel;
    logic   hit;
    logic   refill_done;
    word_t  old_word;
    word_t  merged;

    assign idx      = addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag      = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign word_sel = addr_q[`DC_OFFSET_W-1 -: $bits(beat_t)];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign old_word = data_q[idx][word_sel*`DC_WORD_W +: `DC_WORD_W];
    assign refill_done = (state_q == REFILL) && rd_beat_valid_i && rd_beat_last_i;

    // byte merge of the store word into the cached word
    always_comb begin
        merged = old_word;
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (wstrb_q[b]) begin
                merged[b*8 +: 8] = wdata_q[b*8 +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = RESPOND;
                end else if (valid_q[idx] && dirty_q[idx]) begin
                    state_d = WRITEBACK;    // victim must go out first
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                if (wr_done_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (refill_done) begin
                    state_d = LOOKUP;       // replay, now a hit
                end
            end
            RESPOND: begin
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= IDLE;
            sent_q  <= 1'b0;
            beat_q  <= '0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q != state_d) begin
                sent_q <= 1'b0;
            end else if ((rd_req_valid_o && rd_req_ready_i) ||
                         (wr_req_valid_o && wr_req_ready_i)) begin
                sent_q <= 1'b1;
            end
            if (state_q != REFILL) begin
                beat_q <= '0;
            end else if (rd_beat_valid_i) begin
                beat_q <= beat_q + 1'b1;
            end
            if (state_q == LOOKUP && hit && write_q) begin
                dirty_q[idx] <= 1'b1;
            end
            if (refill_done) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;   // fresh copy from memory
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid_i && req_ready_o) begin
            write_q <= req_write_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            wstrb_q <= req_wstrb_i;
        end
        if (state_q == LOOKUP && hit) begin
            rdata_q <= write_q ? merged : old_word;
        end
    end

    // data and tag arrays
    always_ff @(posedge clock) begin
        if (state_q == LOOKUP && hit && write_q) begin
            data_q[idx][word_sel*`DC_WORD_W +: `DC_WORD_W] <= merged;
        end
        if (state_q == REFILL && rd_beat_valid_i) begin
            data_q[idx][beat_q*`DC_WORD_W +: `DC_WORD_W] <= rd_beat_data_i;
        end
        if (refill_done) begin
            tag_q[idx] <= tag;
        end
    end

    assign req_ready_o    = (state_q == IDLE);
    assign resp_valid_o   = (state_q == RESPOND);
    assign resp_rdata_o   = rdata_q;
    assign rd_req_valid_o = (state_q == REFILL) && !sent_q;
    assign rd_addr_o      = {tag, idx, {`DC_OFFSET_W{1'b0}}};
    assign wr_req_valid_o = (state_q == WRITEBACK) && !sent_q;
    assign wr_addr_o      = {tag_q[idx], idx, {`DC_OFFSET_W{1'b0}}};   // victim line
    assign wr_line_o      = data_q[idx];

    // response is held with stable data while the cpu stalls it
    resp_hold: assert property (@(posedge clock) disable iff (!reset)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o));

    // bridge only delivers beats for a refill we asked for
    beat_in_refill: assert property (@(posedge clock) disable iff (!reset)
        rd_beat_valid_i |-> state_q == REFILL);

endmodule

/* common/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]          addr_t;
    typedef logic [`DC_WORD_W-1:0]          word_t;     // cpu word, also one axi beat
    typedef logic [`DC_WORD_W/8-1:0]        strb_t;
    typedef logic [`DC_LINE_W-1:0]          line_t;
    typedef logic [`DC_TAG_W-1:0]           tag_t;
    typedef logic [`DC_INDEX_W-1:0]         index_t;
    typedef logic [$clog2(`DC_BEATS)-1:0]   beat_t;

    // cache controller
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

    // bridge write side
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_AW,
        WR_W,
        WR_B
    } axi_wr_state_t;

    // bridge read side
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_AR,
        RD_R
    } axi_rd_state_t;

endpackage

/* common/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address and data widths
`define DC_ADDR_W    32
`define DC_WORD_W    64

// line geometry, 16 lines of 4 beats
`define DC_LINE_W    256
`define DC_BEATS     4

// address split: tag | index | offset
`define DC_INDEX_W   4
`define DC_OFFSET_W  5
`define DC_TAG_W     (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif
